// ==== sources.f ====
logic/aon_pkg.sv
logic/sync_chain.sv
logic/adc_result_capture.sv
logic/sleep_wake_sync.sv
logic/pmu_int_regs.sv
logic/aon_pmu_top.sv
bench/clk_gen.sv
bench/aon_pmu_tb.sv

// ==== Makefile ====
# Verilator build and run of the always-on PMU testbench

VERILATOR ?= verilator
TOP       ?= aon_pmu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TEST PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the simulator output
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/aon_pmu_tb.sv ====
// Table driven testbench for the PMU top that drives on falling edges and stops at the first error
`timescale 1ns/10ps
`default_nettype none

module aon_pmu_tb
  import aon_pkg::*;
();

  localparam int SEED   = 66435;
  localparam int SETTLE = 10;  // ns after a drive before combinational outputs are read

  // output selectors for wait entries
  localparam apb_addr_t SIG_IRQ       = 6'd0;
  localparam apb_addr_t SIG_ISO       = 6'd1;
  localparam apb_addr_t SIG_WAKE      = 6'd2;
  localparam apb_addr_t NO_ADDR       = 6'd0;
  localparam apb_addr_t ADDR_UNMAPPED = 6'd9;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_ADC, OP_SLEEP, OP_WAKE, OP_WAIT} op_t;

  typedef struct {
    string     name;
    op_t       op;
    apb_addr_t addr;      // register or output selector for waits
    apb_data_t value;     // write data, sample, level or cycle count
    apb_data_t expected;  // read data or the expected output level in bit 0
  } test_entry_t;

  test_entry_t tests[$];

  logic      clk_16m;
  logic      rstn_16m;
  apb_req_t  apb_req;
  logic      adc_done;
  adc_data_t adc_data;
  logic      sleep_iso;
  logic      wake_event;
  apb_data_t prdata;
  logic      pready;
  logic      pmu_iso;
  logic      cpu_wakeup;
  logic      int_irq;
  int        cycle_count = 0;
  int        cycle_limit = 0;

  clk_gen #(
    .PERIOD_NS    (100),
    .RESET_CYCLES (10)
  ) u_clk_gen (
    .o_clk_16m  (clk_16m),
    .o_rstn_16m (rstn_16m)
  );

  aon_pmu_top #(
    .ADC_SYNC_DEPTH (3),
    .ISO_STAGES     (5),
    .WAKE_STAGES    (5)
  ) uut (
    .clk_16m      (clk_16m),
    .rstn_16m     (rstn_16m),
    .i_apb        (apb_req),
    .o_prdata     (prdata),
    .o_pready     (pready),
    .i_adc_done   (adc_done),
    .i_adc_data   (adc_data),
    .i_sleep_iso  (sleep_iso),
    .i_wake_event (wake_event),
    .o_pmu_iso    (pmu_iso),
    .o_cpu_wakeup (cpu_wakeup),
    .o_int_irq    (int_irq)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input apb_data_t exp, input apb_data_t act);
    if (act !== exp)
    begin
      report_failure($sformatf("FAILED %s expected %08h actual %08h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      report_failure($sformatf("FAILED %s expected %b actual %b", name, exp, act));
    end
  endtask

  function automatic logic output_level(input apb_addr_t sel);
    logic lvl;
    case (sel)
      SIG_ISO:  lvl = pmu_iso;
      SIG_WAKE: lvl = cpu_wakeup;
      default:  lvl = int_irq;
    endcase
    return lvl;
  endfunction

  task automatic add_entry(input string name, input op_t op, input apb_addr_t addr,
                           input apb_data_t value, input apb_data_t expected);
    test_entry_t e;
    e.name     = name;
    e.op       = op;
    e.addr     = addr;
    e.value    = value;
    e.expected = expected;
    tests.push_back(e);
  endtask

  // SETUP then ACCESS with the write landing on the edge that ends ACCESS
  task automatic apb_write(input string name, input apb_addr_t addr, input apb_data_t data);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge clk_16m);
    apb_req.penable = 1'b1;
    #SETTLE;
    check_bit({name, " pready"}, 1'b1, pready);
    check_word({name, " prdata"}, '0, prdata);  // no read data during a write
    @(negedge clk_16m);
    apb_req = '0;
  endtask

  task automatic apb_read(input string name, input apb_addr_t addr, output apb_data_t data);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pwdata  = '0;
    @(negedge clk_16m);
    apb_req.penable = 1'b1;
    #SETTLE;
    check_bit({name, " pready"}, 1'b1, pready);
    data = prdata;  // valid during ACCESS
    @(negedge clk_16m);
    apb_req = '0;
  endtask

  // checks the selected output after each of the given cycles or at once for zero
  task automatic watch_output(input string name, input apb_addr_t sel, input int cycles,
                              input logic exp);
    if (cycles == 0)
    begin
      check_bit(name, exp, output_level(sel));
    end
    for (int i = 0; i < cycles; i++)
    begin
      @(negedge clk_16m);
      check_bit(name, exp, output_level(sel));
    end
  endtask

  task automatic run_entry(input test_entry_t e);
    apb_data_t rdata;
    logic      irq_before;
    case (e.op)
      OP_WRITE:
      begin
        apb_write(e.name, e.addr, e.value);
        check_bit(e.name, e.expected[0], int_irq);
      end
      OP_READ:
      begin
        apb_read(e.name, e.addr, rdata);
        check_word(e.name, e.expected, rdata);
      end
      OP_ADC:
      begin
        irq_before = int_irq;
        adc_data   = e.value[11:0];
        adc_done   = 1'b1;
        repeat (3) @(negedge clk_16m);
        check_bit({e.name, " edge 3"}, irq_before, int_irq);  // status not yet set
        @(negedge clk_16m);             // status bit 0 set at edge 4
        check_bit(e.name, e.expected[0], int_irq);
        adc_done = 1'b0;
        adc_data = ~e.value[11:0];      // bus is free again once done falls
        repeat (3) @(negedge clk_16m);  // done synchronizer drains
      end
      OP_SLEEP:
      begin
        sleep_iso = e.value[0];
        @(negedge clk_16m);
      end
      OP_WAKE:
      begin
        wake_event = e.value[0];
        @(negedge clk_16m);
      end
      default:
      begin
        watch_output(e.name, e.addr, int'(e.value), e.expected[0]);
      end
    endcase
  endtask

  task automatic build_table();
    apb_data_t s1;
    apb_data_t s2;
    apb_data_t s3;
    s1 = $urandom() & 32'h0000_0fff;  // 12 bit samples
    s2 = $urandom() & 32'h0000_0fff;
    s3 = $urandom() & 32'h0000_0fff;
    // reset state
    add_entry("reset irq", OP_WAIT, SIG_IRQ, 1, 0);
    add_entry("reset iso", OP_WAIT, SIG_ISO, 0, 0);
    add_entry("reset wakeup", OP_WAIT, SIG_WAKE, 0, 0);
    add_entry("reset int_sta", OP_READ, REG_INT_STA, 0, 0);
    add_entry("reset int_msk", OP_READ, REG_INT_MSK, 0, 0);
    add_entry("reset adc_data", OP_READ, REG_ADC_DATA, 0, 0);
    add_entry("reset pwr_sta", OP_READ, REG_PWR_STA, 0, 0);
    // adc capture with mask off then on
    add_entry("adc sample 1", OP_ADC, NO_ADDR, s1, 0);
    add_entry("adc sets sta", OP_READ, REG_INT_STA, 0, 1);
    add_entry("adc data 1", OP_READ, REG_ADC_DATA, 0, s1);
    add_entry("unmask adc", OP_WRITE, REG_INT_MSK, 1, 1);
    add_entry("mask readback", OP_READ, REG_INT_MSK, 0, 1);
    // write one to clear
    add_entry("clear none", OP_WRITE, REG_INT_STA, 0, 1);
    add_entry("sta kept", OP_READ, REG_INT_STA, 0, 1);
    add_entry("clear adc", OP_WRITE, REG_INT_STA, 1, 0);
    add_entry("sta cleared", OP_READ, REG_INT_STA, 0, 0);
    add_entry("adc data held", OP_READ, REG_ADC_DATA, 0, s1);
    add_entry("adc sample 2", OP_ADC, NO_ADDR, s2, 1);
    add_entry("adc data 2", OP_READ, REG_ADC_DATA, 0, s2);
    add_entry("clear other bit", OP_WRITE, REG_INT_STA, 2, 1);
    add_entry("clear both", OP_WRITE, REG_INT_STA, 3, 0);
    add_entry("unmapped read", OP_READ, ADDR_UNMAPPED, 0, 0);
    // isolation level
    add_entry("iso raise", OP_SLEEP, NO_ADDR, 1, 0);
    add_entry("iso low edge 2", OP_WAIT, SIG_ISO, 1, 0);
    add_entry("iso high edge 3", OP_WAIT, SIG_ISO, 1, 1);
    add_entry("pwr_sta iso", OP_READ, REG_PWR_STA, 0, 1);
    add_entry("iso drop", OP_SLEEP, NO_ADDR, 0, 0);
    add_entry("iso held edges 2-6", OP_WAIT, SIG_ISO, 5, 1);
    add_entry("iso low edge 7", OP_WAIT, SIG_ISO, 1, 0);
    add_entry("pwr_sta iso off", OP_READ, REG_PWR_STA, 0, 0);
    // one cycle pulse
    add_entry("iso pulse on", OP_SLEEP, NO_ADDR, 1, 0);
    add_entry("iso pulse off", OP_SLEEP, NO_ADDR, 0, 0);
    add_entry("iso window", OP_WAIT, SIG_ISO, 5, 1);
    add_entry("iso window end", OP_WAIT, SIG_ISO, 1, 0);
    // wake path with both sources enabled
    add_entry("unmask both", OP_WRITE, REG_INT_MSK, 3, 0);
    add_entry("wake raise", OP_WAKE, NO_ADDR, 1, 0);
    add_entry("wakeup low edges 2-4", OP_WAIT, SIG_WAKE, 3, 0);
    add_entry("wakeup high edge 5", OP_WAIT, SIG_WAKE, 1, 1);
    add_entry("irq before wake sta", OP_WAIT, SIG_IRQ, 0, 0);
    add_entry("irq from wake", OP_WAIT, SIG_IRQ, 1, 1);
    add_entry("wake sets sta", OP_READ, REG_INT_STA, 0, 2);
    add_entry("pwr_sta wake", OP_READ, REG_PWR_STA, 0, 2);
    add_entry("adc sample 3", OP_ADC, NO_ADDR, s3, 1);
    add_entry("both set", OP_READ, REG_INT_STA, 0, 3);
    add_entry("clear adc only", OP_WRITE, REG_INT_STA, 1, 1);
    add_entry("clear wake", OP_WRITE, REG_INT_STA, 2, 0);
    add_entry("all clear", OP_READ, REG_INT_STA, 0, 0);
    add_entry("adc data 3", OP_READ, REG_ADC_DATA, 0, s3);
    add_entry("wake drop", OP_WAKE, NO_ADDR, 0, 0);
    add_entry("wakeup held edges 2-4", OP_WAIT, SIG_WAKE, 3, 1);
    add_entry("wakeup low edge 5", OP_WAIT, SIG_WAKE, 1, 0);
    add_entry("wake fall no sta", OP_READ, REG_INT_STA, 0, 0);
    add_entry("pwr_sta final", OP_READ, REG_PWR_STA, 0, 0);
  endtask

  // run length guard
  always @(posedge clk_16m)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      report_failure($sformatf("timeout: tests did not finish within %0d cycles", cycle_limit));
    end
  end

  initial
  begin
    apb_req    = '0;
    adc_done   = 1'b0;
    adc_data   = '0;
    sleep_iso  = 1'b0;
    wake_event = 1'b0;
    void'($urandom(SEED));
    build_table();
    cycle_limit = tests.size() * 20 + 100;
    @(posedge rstn_16m);
    @(negedge clk_16m);
    foreach (tests[i])
    begin
      run_entry(tests[i]);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
// Free running testbench clock with a power-on reset that is released on a falling edge
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic o_clk_16m,
  output logic o_rstn_16m
);

  initial
  begin
    o_clk_16m = 1'b0;
    forever
    begin
      #(PERIOD_NS / 2) o_clk_16m = ~o_clk_16m;
    end
  end

  initial
  begin
    o_rstn_16m = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk_16m);
    @(negedge o_clk_16m);
    o_rstn_16m = 1'b1;  // away from the rising edge
  end

endmodule

`default_nettype wire

// ==== logic/aon_pmu_top.sv ====
// Fast clock side of the always-on PMU, every input is sampled on clk_16m with one async reset
`timescale 1ns/10ps
`default_nettype none

module aon_pmu_top
  import aon_pkg::*;
#(
  parameter int ADC_SYNC_DEPTH = 3,
  parameter int ISO_STAGES     = 5,
  parameter int WAKE_STAGES    = 5
) (
  input  wire logic      clk_16m,
  input  wire logic      rstn_16m,
  // APB slave
  input  wire apb_req_t  i_apb,
  output apb_data_t      o_prdata,
  output logic           o_pready,
  // ADC
  input  wire logic      i_adc_done,
  input  wire adc_data_t i_adc_data,
  // sleep controller
  input  wire logic      i_sleep_iso,
  input  wire logic      i_wake_event,
  // outputs to core and analog
  output logic           o_pmu_iso,
  output logic           o_cpu_wakeup,
  output logic           o_int_irq
);

  adc_result_t adc_result;
  pwr_state_t  pwr;

  adc_result_capture #(
    .ADC_SYNC_DEPTH (ADC_SYNC_DEPTH)
  ) u_adc_result_capture (
    .clk_16m    (clk_16m),
    .rstn_16m   (rstn_16m),
    .i_adc_done (i_adc_done),
    .i_adc_data (i_adc_data),
    .o_result   (adc_result)
  );

  sleep_wake_sync #(
    .ISO_STAGES  (ISO_STAGES),
    .WAKE_STAGES (WAKE_STAGES)
  ) u_sleep_wake_sync (
    .clk_16m      (clk_16m),
    .rstn_16m     (rstn_16m),
    .i_sleep_iso  (i_sleep_iso),
    .i_wake_event (i_wake_event),
    .o_pwr        (pwr)
  );

  pmu_int_regs u_pmu_int_regs (
    .clk_16m   (clk_16m),
    .rstn_16m  (rstn_16m),
    .i_apb     (i_apb),
    .i_result  (adc_result),
    .i_pwr     (pwr),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_int_irq (o_int_irq)
  );

  assign o_pmu_iso    = pwr.iso;   // to analog isolation cells
  assign o_cpu_wakeup = pwr.wake;  // to core

endmodule

`default_nettype wire

// ==== logic/pmu_int_regs.sv ====
// APB interrupt and status registers with no wait states, unmapped addresses read zero and ignore writes
`timescale 1ns/10ps
`default_nettype none

module pmu_int_regs
  import aon_pkg::*;
(
  input  wire logic        clk_16m,
  input  wire logic        rstn_16m,
  input  wire apb_req_t    i_apb,
  input  wire adc_result_t i_result,
  input  wire pwr_state_t  i_pwr,
  output apb_data_t        o_prdata,
  output logic             o_pready,
  output logic             o_int_irq
);

  logic     access;
  logic     wr_en;
  logic     rd_en;
  logic     sta_wr;
  logic     msk_wr;
  logic     wake_d;
  logic     wake_rise;
  int_vec_t int_set;
  int_vec_t int_clr;
  int_vec_t int_sta;
  int_vec_t int_msk;

  // APB decode
  assign access = i_apb.psel & i_apb.penable;
  assign wr_en  = access & i_apb.pwrite;
  assign rd_en  = access & ~i_apb.pwrite;
  assign sta_wr = wr_en && (i_apb.paddr == REG_INT_STA);
  assign msk_wr = wr_en && (i_apb.paddr == REG_INT_MSK);

  assign o_pready = access;  // no wait states

  // wake level rising edge
  always_ff @(posedge clk_16m or negedge rstn_16m)
  begin
    if (!rstn_16m)
    begin
      wake_d <= 1'b0;
    end
    else
    begin
      wake_d <= i_pwr.wake;
    end
  end

  assign wake_rise = i_pwr.wake & ~wake_d;

  assign int_set = {wake_rise, i_result.captured};
  assign int_clr = sta_wr ? i_apb.pwdata[1:0] : '0;  // write one to clear

  // status and mask
  always_ff @(posedge clk_16m or negedge rstn_16m)
  begin
    if (!rstn_16m)
    begin
      int_sta <= '0;
      int_msk <= '0;
    end
    else
    begin
      int_sta <= (int_sta & ~int_clr) | int_set;  // set wins over clear
      if (msk_wr)
      begin
        int_msk <= i_apb.pwdata[1:0];
      end
    end
  end

  assign o_int_irq = |(int_sta & int_msk);

  // read mux, valid during ACCESS only
  always_comb
  begin
    o_prdata = '0;
    if (rd_en)
    begin
      case (i_apb.paddr)
        REG_INT_STA:  o_prdata = {30'd0, int_sta};
        REG_INT_MSK:  o_prdata = {30'd0, int_msk};
        REG_ADC_DATA: o_prdata = {20'd0, i_result.data};
        REG_PWR_STA:  o_prdata = {30'd0, i_pwr};  // bit 1 wake, bit 0 iso
        default:      o_prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/sleep_wake_sync.sv ====
// Sleep isolation stretch and wake delay into clk_16m, inputs are slow levels from the sleep controller
`timescale 1ns/10ps
`default_nettype none

module sleep_wake_sync
  import aon_pkg::*;
#(
  parameter int ISO_STAGES  = 5,   // stages ORed into the isolation level
  parameter int WAKE_STAGES = 5    // total flops from wake event to wake level
) (
  input  wire logic clk_16m,
  input  wire logic rstn_16m,
  input  wire logic i_sleep_iso,   // async level
  input  wire logic i_wake_event,  // async level
  output pwr_state_t o_pwr
);

  // first iso flop is only a capture stage and is left out of the OR
  localparam int ISO_DEPTH  = ISO_STAGES + 1;
  // last wake flop is the output register below
  localparam int WAKE_DEPTH = WAKE_STAGES - 1;

  logic [ISO_DEPTH-1:0]  iso_stages;
  logic [WAKE_DEPTH-1:0] wake_stages;
  logic                  iso_any;

  sync_chain #(
    .DEPTH    (ISO_DEPTH)
  ) u_iso_sync (
    .clk_16m  (clk_16m),
    .rstn_16m (rstn_16m),
    .i_async  (i_sleep_iso),
    .o_stages (iso_stages)
  );

  sync_chain #(
    .DEPTH    (WAKE_DEPTH)
  ) u_wake_sync (
    .clk_16m  (clk_16m),
    .rstn_16m (rstn_16m),
    .i_async  (i_wake_event),
    .o_stages (wake_stages)
  );

  // isolation rises early and drops only once the whole chain is clear
  assign iso_any = |iso_stages[ISO_DEPTH-1:1];

  always_ff @(posedge clk_16m or negedge rstn_16m)
  begin
    if (!rstn_16m)
    begin
      o_pwr.iso  <= 1'b0;
      o_pwr.wake <= 1'b0;
    end
    else
    begin
      o_pwr.iso  <= iso_any;                    // glitch free stretched level
      o_pwr.wake <= wake_stages[WAKE_DEPTH-1];
    end
  end

endmodule

`default_nettype wire

// ==== logic/adc_result_capture.sv ====
// ADC sample capture on the synchronized done edge, data must stay stable while done is high
`timescale 1ns/10ps
`default_nettype none

module adc_result_capture
  import aon_pkg::*;
#(
  parameter int ADC_SYNC_DEPTH = 3
) (
  input  wire logic      clk_16m,
  input  wire logic      rstn_16m,
  input  wire logic      i_adc_done,   // async completion strobe
  input  wire adc_data_t i_adc_data,   // async sample bus
  output adc_result_t    o_result
);

  logic [ADC_SYNC_DEPTH-1:0] done_stages;
  logic                      done_rise;

  sync_chain #(
    .DEPTH    (ADC_SYNC_DEPTH)
  ) u_done_sync (
    .clk_16m  (clk_16m),
    .rstn_16m (rstn_16m),
    .i_async  (i_adc_done),
    .o_stages (done_stages)
  );

  // rising edge seen between the last two stages
  assign done_rise = done_stages[ADC_SYNC_DEPTH-2] & ~done_stages[ADC_SYNC_DEPTH-1];

  // sample bus has been stable for several cycles by the time the edge is seen
  always_ff @(posedge clk_16m or negedge rstn_16m)
  begin
    if (!rstn_16m)
    begin
      o_result.captured <= 1'b0;
      o_result.data     <= '0;
    end
    else
    begin
      o_result.captured <= done_rise;       // single cycle pulse
      if (done_rise)
      begin
        o_result.data <= i_adc_data;        // hold until next capture
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/sync_chain.sv ====
// Level synchronizer into clk_16m with every stage visible, only for slow levels and not for buses
`timescale 1ns/10ps
`default_nettype none

module sync_chain #(
  parameter int DEPTH = 3
) (
  input  wire logic             clk_16m,
  input  wire logic             rstn_16m,
  input  wire logic             i_async,   // asynchronous level
  output logic      [DEPTH-1:0] o_stages   // stage 0 is the first flop
);

  always_ff @(posedge clk_16m or negedge rstn_16m)
  begin
    if (!rstn_16m)
    begin
      o_stages <= '0;
    end
    else
    begin
      o_stages[0] <= i_async;
      for (int i = 1; i < DEPTH; i++)
      begin
        o_stages[i] <= o_stages[i-1];  // shift toward the last stage
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/aon_pkg.sv ====
// Shared types and APB register offsets of the always-on PMU block, addresses are word offsets
`default_nettype none

package aon_pkg;

  // widths with a meaning of their own
  typedef logic [11:0] adc_data_t;     // one ADC conversion result
  typedef logic [5:0]  apb_addr_t;     // byte address bits 7 down to 2
  typedef logic [31:0] apb_data_t;
  typedef logic [1:0]  int_vec_t;      // bit 0 adc capture, bit 1 wake

  // APB master request, 41 bits
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // ADC capture result, 13 bits
  typedef struct packed {
    logic      captured;               // one clk_16m cycle per sample
    adc_data_t data;                   // holds until next capture
  } adc_result_t;

  // power state as seen in clk_16m, wake is bit 1 and iso is bit 0
  typedef struct packed {
    logic wake;
    logic iso;
  } pwr_state_t;

  // register word offsets
  localparam apb_addr_t REG_INT_STA  = 6'd0;  // w1c
  localparam apb_addr_t REG_INT_MSK  = 6'd1;
  localparam apb_addr_t REG_ADC_DATA = 6'd2;  // read only
  localparam apb_addr_t REG_PWR_STA  = 6'd3;  // read only

endpackage

`default_nettype wire
